//--- Makefile
# Verilator build and run of the CSR file testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000

FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
verilog/csr_arch_pkg.sv
verilog/csr_port_pkg.sv
verilog/csr_write_ctrl.sv
verilog/csr_trap_regs.sv
verilog/csr_counters.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
verification/csr_checker.sv
verification/csr_tb.sv

//--- verification/csr_checker.sv
// Concurrent checks on the CSR file, bound into csr_top
// Covers read flags without a request, the trap entry result and the inhibited cycle counter

`timescale 1ns/1ns

module csr_checker (
  input logic                               clk,
  input logic                               rst_n,
  input csr_port_pkg::csr_rd_req_t          rd_req_i,
  input csr_port_pkg::trap_ctrl_t           trap_i,
  input csr_port_pkg::csr_wr_strobe_t       strobe_i,
  input logic                               illegal_i,        // csr_illegal_o
  input logic                               counter_read_i,   // csr_counter_read_o
  input logic                               irq_enable_i,     // m_irq_enable_o
  input logic [csr_arch_pkg::XLEN-1:0]      mepc_i,
  input logic [csr_arch_pkg::CNT_WIDTH-1:0] mcycle_i,
  input logic [csr_arch_pkg::XLEN-1:0]      mcountinhibit_i
);

  int unsigned fail_cnt = 0;  // Failed assertion count

  logic cycle_wr;  // Software write to either mcycle half
  assign cycle_wr = strobe_i.mcycle_lo | strobe_i.mcycle_hi;

  // No request, no flags
  idle_flags_a: assert property (@(posedge clk) disable iff (!rst_n)
    !rd_req_i.valid |-> !illegal_i && !counter_read_i)
    else begin
      $error("illegal or counter flag raised without a valid read request");
      fail_cnt++;
    end

  // Trap entry masks interrupts and saves the halfword aligned epc
  trap_save_a: assert property (@(posedge clk) disable iff (!rst_n)
    trap_i.save_cause |=> !irq_enable_i && (mepc_i == ($past(trap_i.epc) & ~32'h1)))
    else begin
      $error("trap save did not clear the interrupt enable or load mepc");
      fail_cnt++;
    end

  // CY inhibited and no software write, so mcycle must hold
  cycle_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    mcountinhibit_i[0] && !cycle_wr |=> mcycle_i == $past(mcycle_i))
    else begin
      $error("mcycle moved while inhibited");
      fail_cnt++;
    end

endmodule

bind csr_top csr_checker u_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .rd_req_i       (rd_req_i),
  .trap_i         (trap_i),
  .strobe_i       (strobe),
  .illegal_i      (csr_illegal_o),
  .counter_read_i (csr_counter_read_o),
  .irq_enable_i   (m_irq_enable_o),
  .mepc_i         (mepc_o),
  .mcycle_i       (mcycle),
  .mcountinhibit_i(mcountinhibit)
);

//--- verification/csr_tb.sv
// Testbench for the machine-mode CSR file
// Drives read, write, trap and retire inputs on the falling edge and checks
// read data and flags against the architectural rules

`timescale 1ns/1ns

module csr_tb;

  import csr_arch_pkg::*;
  import csr_port_pkg::*;

  localparam int unsigned SEED = 50646;

  logic clk = 1'b0;
  logic rst_n;
  csr_rd_req_t rd_req;
  csr_wr_req_t wr_req;
  trap_ctrl_t  trap;
  logic        retire;
  logic [31:0] hart_id, mip;
  logic [31:0] csr_rdata, mie, mepc;
  logic        csr_illegal, csr_counter_read, irq_en;
  logic [23:0] mtvec_base;
  logic [1:0]  mtvec_mode;

  logic [31:0] rd_data;             // Sampled read port
  logic        rd_ill, rd_cnt;
  int          errors, checks, tests, test_base;

  always #2 clk = ~clk;             // 4 ns period

  csr_top u_csr_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .rd_req_i           (rd_req),
    .wr_req_i           (wr_req),
    .trap_i             (trap),
    .retire_i           (retire),
    .hart_id_i          (hart_id),
    .mip_i              (mip),
    .csr_rdata_o        (csr_rdata),
    .csr_illegal_o      (csr_illegal),
    .csr_counter_read_o (csr_counter_read),
    .mie_o              (mie),
    .mepc_o             (mepc),
    .mtvec_base_o       (mtvec_base),
    .mtvec_mode_o       (mtvec_mode),
    .m_irq_enable_o     (irq_en)
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s expected 0x%08h got 0x%08h", name, exp, got);
      errors++;
    end
  endtask

  // Combinational port is sampled 1 ns after the drive edge
  task automatic read_csr(input csr_num_e addr, input csr_op_e op);
    @(negedge clk);
    rd_req = '{valid: 1'b1, addr: addr, op: op};
    #1;
    rd_data = csr_rdata;
    rd_ill  = csr_illegal;
    rd_cnt  = csr_counter_read;
  endtask

  task automatic write_csr(input csr_num_e addr, input csr_op_e op,
                           input logic [31:0] wdata, input logic [31:0] old);
    @(negedge clk);
    wr_req = '{valid: 1'b1, addr: addr, op: op, wdata: wdata, rdata_old: old};
    @(negedge clk);
    wr_req.valid = 1'b0;            // Landed on the edge in between
  endtask

  task automatic pulse_trap(input logic save, input logic mret, input logic [31:0] cause,
                            input logic [31:0] epc);
    @(negedge clk);
    trap = '{save_cause: save, restore_mret: mret, cause: cause, epc: epc};
    @(negedge clk);
    trap.save_cause   = 1'b0;
    trap.restore_mret = 1'b0;
  endtask

  task automatic wait_irq_enable(input logic exp, input int max_cycles);
    int n;
    n = 0;
    while (irq_en !== exp && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (irq_en !== exp) begin
      $display("Timeout: m_irq_enable_o never became %0d", exp);
      errors++;
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) @(negedge clk);
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    rd_req.valid = 1'b0;            // Idle read port between tests
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - test_base);
    test_base = errors;
  endtask

  initial begin
    csr_num_e    addrs[3];
    csr_op_e     op;
    logic [31:0] w, old, exp, cause, epc, c0;
    int          n;
    addrs = '{CSR_MSCRATCH, CSR_MIE, CSR_MEPC};
    errors = 0;
    checks = 0;
    tests = 0;
    test_base = 0;
    w = $urandom(SEED);
    rst_n = 1'b0;
    rd_req = '0;
    wr_req = '0;
    trap = '0;
    retire = 1'b0;
    hart_id = $urandom;
    mip = $urandom;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    ////////////////////////////////////////////////////////////
    // Reset values
    read_csr(CSR_MSTATUS, CSR_OP_READ);
    check_value("mstatus", rd_data, 32'h0000_1800);
    read_csr(CSR_MTVEC, CSR_OP_READ);
    check_value("mtvec", rd_data, 32'h0000_0101);
    read_csr(CSR_MISA, CSR_OP_READ);
    check_value("misa", rd_data, 32'h4000_1104);
    read_csr(CSR_MHARTID, CSR_OP_READ);
    check_value("mhartid", rd_data, hart_id);
    read_csr(CSR_MIP, CSR_OP_READ);
    check_value("mip", rd_data, mip);
    read_csr(CSR_MCYCLE, CSR_OP_READ);
    check_value("mcycle", rd_data, 32'h0);
    check_value("m_irq_enable_o", irq_en, 32'h0);
    check_value("mie_o", mie, 32'h0);
    check_value("mepc_o", mepc, 32'h0);
    check_value("mtvec_base_o", mtvec_base, 32'h1);
    check_value("mtvec_mode_o", mtvec_mode, 32'h1);
    end_test("reset_values");

    ////////////////////////////////////////////////////////////
    // Read-modify-write with WRITE first so mscratch starts from a known value
    for (int i = 0; i < 9; i++) begin
      case (i % 3)
        0: op = CSR_OP_WRITE;
        1: op = CSR_OP_SET;
        default: op = CSR_OP_CLEAR;
      endcase
      foreach (addrs[a]) begin
        w = $urandom;
        read_csr(addrs[a], CSR_OP_READ);
        old = rd_data;
        case (op)
          CSR_OP_WRITE: exp = w;
          CSR_OP_SET:   exp = old | w;
          default:      exp = old & ~w;
        endcase
        if (addrs[a] == CSR_MIE) exp = exp & 32'hFFFF_0888;   // MSI, MTI, MEI, 16..31
        if (addrs[a] == CSR_MEPC) exp = exp & ~32'h1;         // Bit 0 reads zero
        write_csr(addrs[a], op, w, old);
        read_csr(addrs[a], CSR_OP_READ);
        check_value(addrs[a].name(), rd_data, exp);
      end
    end
    end_test("read_modify_write");

    ////////////////////////////////////////////////////////////
    // Illegal accesses and counter flag
    read_csr(CSR_MINSTRETH, CSR_OP_READ);
    check_value("csr_counter_read_o", rd_cnt, 32'h1);
    read_csr(CSR_MSCRATCH, CSR_OP_READ);
    check_value("csr_counter_read_o", rd_cnt, 32'h0);
    read_csr(CSR_MHARTID, CSR_OP_READ);
    check_value("csr_illegal_o", rd_ill, 32'h0);
    read_csr(CSR_MHARTID, CSR_OP_WRITE);
    check_value("csr_illegal_o", rd_ill, 32'h1);
    // Unimplemented address last, the idle port after it still decodes it
    read_csr(csr_num_e'(12'h7C0), CSR_OP_READ);
    check_value("csr_illegal_o", rd_ill, 32'h1);
    end_test("illegal_access");

    ////////////////////////////////////////////////////////////
    // Trap entry, MRET, then trap against a software mepc write
    read_csr(CSR_MSTATUS, CSR_OP_READ);
    write_csr(CSR_MSTATUS, CSR_OP_SET, 32'h8, rd_data);
    wait_irq_enable(1'b1, 10);
    cause = $urandom;
    epc   = $urandom;
    pulse_trap(1'b1, 1'b0, cause, epc);
    wait_irq_enable(1'b0, 10);
    read_csr(CSR_MEPC, CSR_OP_READ);
    check_value("mepc", rd_data, epc & ~32'h1);
    read_csr(CSR_MCAUSE, CSR_OP_READ);
    check_value("mcause", rd_data, cause & 32'h8000_00FF);
    read_csr(CSR_MSTATUS, CSR_OP_READ);
    check_value("mstatus", rd_data, 32'h0000_1880);
    pulse_trap(1'b0, 1'b1, '0, '0);
    wait_irq_enable(1'b1, 10);
    read_csr(CSR_MSTATUS, CSR_OP_READ);
    check_value("mstatus", rd_data, 32'h0000_1888);
    epc = $urandom;
    w   = ~epc;
    @(negedge clk);
    trap   = '{save_cause: 1'b1, restore_mret: 1'b0, cause: cause, epc: epc};
    wr_req = '{valid: 1'b1, addr: CSR_MEPC, op: CSR_OP_WRITE, wdata: w, rdata_old: '0};
    @(negedge clk);
    trap.save_cause = 1'b0;
    wr_req.valid    = 1'b0;
    read_csr(CSR_MEPC, CSR_OP_READ);
    check_value("mepc", rd_data, epc & ~32'h1);
    end_test("trap_mret");

    ////////////////////////////////////////////////////////////
    // Counters
    write_csr(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h0, 32'h5);
    n = 5 + int'($urandom % 20);
    read_csr(CSR_MCYCLE, CSR_OP_READ);
    c0 = rd_data;
    wait_cycles(n - 1);
    read_csr(CSR_MCYCLE, CSR_OP_READ);
    check_value("mcycle delta", rd_data - c0, n);
    read_csr(CSR_MINSTRET, CSR_OP_READ);
    c0 = rd_data;
    n  = 1 + int'($urandom % 10);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      retire = 1'b1;
      @(negedge clk);
      retire = 1'b0;
      wait_cycles(int'($urandom % 3));   // Uneven gaps between retirements
    end
    read_csr(CSR_MINSTRET, CSR_OP_READ);
    check_value("minstret delta", rd_data - c0, n);
    w = $urandom;
    write_csr(CSR_MCYCLEH, CSR_OP_WRITE, w, 32'h0);
    read_csr(CSR_MCYCLEH, CSR_OP_READ);
    check_value("mcycleh", rd_data, w);
    write_csr(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'hFFFF_FFFF, 32'h0);
    read_csr(CSR_MCOUNTINHIBIT, CSR_OP_READ);
    check_value("mcountinhibit", rd_data, 32'h5);
    read_csr(CSR_MCYCLE, CSR_OP_READ);
    c0 = rd_data;
    wait_cycles(10);
    read_csr(CSR_MCYCLE, CSR_OP_READ);
    check_value("mcycle held", rd_data, c0);
    end_test("counters");

    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, u_csr_top.u_checker.fail_cnt);
    if (errors == 0 && u_csr_top.u_checker.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verilog/csr_arch_pkg.sv
// Architectural definitions for the machine-mode CSR file
// Addresses, operation codes, register layouts and reset constants
// Shared by the write control, register blocks and the read decode

package csr_arch_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int XLEN      = 32;  // Data path width
  localparam int CNT_WIDTH = 64;  // mcycle / minstret width

  localparam logic [1:0] PRIV_M = 2'b11;  // Machine privilege, the only mode

  // Implemented CSR addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,  // Reads zero
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MVENDORID     = 12'hF11,  // Reads zero
    CSR_MARCHID       = 12'hF12,  // Reads zero
    CSR_MIMPID        = 12'hF13,  // Reads zero
    CSR_MHARTID       = 12'hF14
  } csr_num_e;

  // CSR instruction flavours, READ never writes
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////
  // Register layouts
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [18:0] zero3;
    logic [1:0]  mpp;             // Bits 12:11
    logic [2:0]  zero2;
    logic        mpie;            // Bit 7
    logic [2:0]  zero1;
    logic        mie;             // Bit 3
    logic [2:0]  zero0;
  } mstatus_t;

  typedef struct packed {
    logic        interrupt;       // Bit 31
    logic [22:0] zero0;
    logic [7:0]  exception_code;  // Bits 7:0
  } mcause_t;

  typedef struct packed {
    logic [23:0] base;            // 256-byte aligned handler base
    logic [5:0]  zero0;
    logic [1:0]  mode;            // Only bit 0 is writable
  } mtvec_t;

  // MXL = 1 (RV32), extensions C, I and M
  localparam logic [31:0] MISA_VALUE        = 32'h4000_1104;
  localparam logic [31:0] MSTATUS_RESET_VAL = {19'd0, PRIV_M, 11'd0};
  localparam logic [31:0] MTVEC_RESET_VAL   = 32'h0000_0101;  // Base 0x000001, vectored
  localparam logic [31:0] IRQ_MASK          = 32'hFFFF_0888;  // MSI, MTI, MEI, fast irqs
  localparam logic [31:0] CNT_INHIBIT_MASK  = 32'h0000_0005;  // CY and IR only

endpackage

//--- verilog/csr_counters.sv
// mcycle and minstret counters with mcountinhibit
// Each 32-bit half is writable, a write beats the increment
// Both counters come out of reset inhibited

`timescale 1ns/1ns

module csr_counters (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [csr_arch_pkg::XLEN-1:0]      wdata_i,
  input  csr_port_pkg::csr_wr_strobe_t       strobe_i,
  input  logic                               retire_i,        // One pulse per retirement
  output logic [csr_arch_pkg::CNT_WIDTH-1:0] mcycle_o,
  output logic [csr_arch_pkg::CNT_WIDTH-1:0] minstret_o,
  output logic [csr_arch_pkg::XLEN-1:0]      mcountinhibit_o
);

  import csr_arch_pkg::*;

  localparam int NUM_CNT = 2;  // Index 0 is mcycle, 1 is minstret

  logic [XLEN-1:0]    mcountinhibit_q;
  logic [NUM_CNT-1:0] wr_lo;    // Low half write
  logic [NUM_CNT-1:0] wr_hi;    // High half write
  logic [NUM_CNT-1:0] inc_en;   // Count this cycle

  assign wr_lo  = {strobe_i.minstret_lo, strobe_i.mcycle_lo};
  assign wr_hi  = {strobe_i.minstret_hi, strobe_i.mcycle_hi};

  // Inhibit bit 0 is CY, bit 2 is IR
  assign inc_en = {~mcountinhibit_q[2] & retire_i, ~mcountinhibit_q[0]};

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_CNT; i++) begin : g_cnt
    logic [CNT_WIDTH-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q <= '0;
      end else if (wr_lo[i]) begin
        cnt_q[XLEN-1:0] <= wdata_i;            // High half holds
      end else if (wr_hi[i]) begin
        cnt_q[CNT_WIDTH-1:XLEN] <= wdata_i;
      end else if (inc_en[i]) begin
        cnt_q <= cnt_q + CNT_WIDTH'(1);
      end
    end
  end

  // Only CY and IR exist, the other inhibit bits read zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcountinhibit_q <= CNT_INHIBIT_MASK;   // Start inhibited
    end else if (strobe_i.mcountinhibit) begin
      mcountinhibit_q <= wdata_i & CNT_INHIBIT_MASK;
    end
  end

  assign mcycle_o        = g_cnt[0].cnt_q;
  assign minstret_o      = g_cnt[1].cnt_q;
  assign mcountinhibit_o = mcountinhibit_q;

endmodule

//--- verilog/csr_port_pkg.sv
// Pipeline-side bundles of the CSR file
// Read request from execute, write request from writeback,
// trap control from the controller and the internal write strobes

package csr_port_pkg;

  // Execute stage read, decoded combinationally
  typedef struct packed {
    logic                 valid;
    csr_arch_pkg::csr_num_e addr;
    csr_arch_pkg::csr_op_e  op;
  } csr_rd_req_t;

  // Writeback stage write, rdata_old is the value read in execute
  typedef struct packed {
    logic                            valid;
    csr_arch_pkg::csr_num_e          addr;
    csr_arch_pkg::csr_op_e           op;
    logic [csr_arch_pkg::XLEN-1:0]   wdata;      // Instruction operand
    logic [csr_arch_pkg::XLEN-1:0]   rdata_old;  // Operand for SET / CLEAR
  } csr_wr_req_t;

  // From the controller, save_cause and restore_mret never coincide
  typedef struct packed {
    logic                          save_cause;    // Trap entry pulse
    logic                          restore_mret;  // MRET pulse
    csr_arch_pkg::mcause_t         cause;
    logic [csr_arch_pkg::XLEN-1:0] epc;
  } trap_ctrl_t;

  // One enable per writable register, at most one bit set
  typedef struct packed {
    logic mstatus;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mcycle_lo;
    logic mcycle_hi;
    logic minstret_lo;
    logic minstret_hi;
    logic mcountinhibit;
  } csr_wr_strobe_t;

endpackage

//--- verilog/csr_read_mux.sv
// Execute stage read port of the CSR file
// Selects read data by address and flags illegal or counter accesses
// Fully combinational, results are valid in the request cycle

`timescale 1ns/1ns

module csr_read_mux (
  input  csr_port_pkg::csr_rd_req_t          rd_req_i,
  input  csr_arch_pkg::mstatus_t             mstatus_i,
  input  logic [csr_arch_pkg::XLEN-1:0]      mie_i,
  input  csr_arch_pkg::mtvec_t               mtvec_i,
  input  logic [csr_arch_pkg::XLEN-1:0]      mscratch_i,
  input  logic [csr_arch_pkg::XLEN-1:0]      mepc_i,
  input  csr_arch_pkg::mcause_t              mcause_i,
  input  logic [csr_arch_pkg::CNT_WIDTH-1:0] mcycle_i,
  input  logic [csr_arch_pkg::CNT_WIDTH-1:0] minstret_i,
  input  logic [csr_arch_pkg::XLEN-1:0]      mcountinhibit_i,
  input  logic [csr_arch_pkg::XLEN-1:0]      hart_id_i,
  input  logic [csr_arch_pkg::XLEN-1:0]      mip_i,
  output logic [csr_arch_pkg::XLEN-1:0]      csr_rdata_o,
  output logic                               csr_illegal_o,
  output logic                               csr_counter_read_o
);

  import csr_arch_pkg::*;

  logic [XLEN-1:0] rdata;
  logic            implemented;  // Address decodes to a CSR
  logic            counter_rd;   // Any counter half
  logic            ro_write;     // Write attempt in the 0b11 read-only space

  always_comb begin
    rdata       = '0;
    implemented = 1'b1;
    counter_rd  = 1'b0;
    case (rd_req_i.addr)
      CSR_MSTATUS:       rdata = mstatus_i;
      CSR_MISA:          rdata = MISA_VALUE;
      CSR_MIE:           rdata = mie_i;
      CSR_MTVEC:         rdata = mtvec_i;
      CSR_MCOUNTINHIBIT: rdata = mcountinhibit_i;
      CSR_MSCRATCH:      rdata = mscratch_i;
      CSR_MEPC:          rdata = mepc_i;
      CSR_MCAUSE:        rdata = mcause_i;
      CSR_MIP:           rdata = mip_i;
      CSR_MHARTID:       rdata = hart_id_i;
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MTVAL: rdata = '0;  // Read zero
      CSR_MCYCLE: begin
        rdata      = mcycle_i[XLEN-1:0];
        counter_rd = 1'b1;
      end
      CSR_MCYCLEH: begin
        rdata      = mcycle_i[CNT_WIDTH-1:XLEN];
        counter_rd = 1'b1;
      end
      CSR_MINSTRET: begin
        rdata      = minstret_i[XLEN-1:0];
        counter_rd = 1'b1;
      end
      CSR_MINSTRETH: begin
        rdata      = minstret_i[CNT_WIDTH-1:XLEN];
        counter_rd = 1'b1;
      end
      default: implemented = 1'b0;
    endcase
  end

  // Top two address bits both set means read-only
  assign ro_write = (rd_req_i.op != CSR_OP_READ) && (rd_req_i.addr[11:10] == 2'b11);

  assign csr_rdata_o        = rd_req_i.valid ? rdata : '0;
  assign csr_illegal_o      = rd_req_i.valid & (~implemented | ro_write);
  assign csr_counter_read_o = rd_req_i.valid & counter_rd;

endmodule

//--- verilog/csr_top.sv
// Machine-mode CSR file of the RV32 core
// Reads in execute return data the same cycle, writes in writeback land
// one cycle later, trap entry and MRET come from the controller

`timescale 1ns/1ns

module csr_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  csr_port_pkg::csr_rd_req_t     rd_req_i,
  input  csr_port_pkg::csr_wr_req_t     wr_req_i,
  input  csr_port_pkg::trap_ctrl_t      trap_i,
  input  logic                          retire_i,
  input  logic [csr_arch_pkg::XLEN-1:0] hart_id_i,
  input  logic [csr_arch_pkg::XLEN-1:0] mip_i,
  output logic [csr_arch_pkg::XLEN-1:0] csr_rdata_o,
  output logic                          csr_illegal_o,
  output logic                          csr_counter_read_o,
  output logic [csr_arch_pkg::XLEN-1:0] mie_o,
  output logic [csr_arch_pkg::XLEN-1:0] mepc_o,
  output logic [23:0]                   mtvec_base_o,
  output logic [1:0]                    mtvec_mode_o,
  output logic                          m_irq_enable_o
);

  import csr_arch_pkg::*;
  import csr_port_pkg::*;

  logic [XLEN-1:0]      wdata;          // Post-operation write value
  csr_wr_strobe_t       strobe;
  mstatus_t             mstatus;
  mtvec_t               mtvec;
  logic [XLEN-1:0]      mscratch;
  mcause_t              mcause;
  logic [CNT_WIDTH-1:0] mcycle;
  logic [CNT_WIDTH-1:0] minstret;
  logic [XLEN-1:0]      mcountinhibit;

  csr_write_ctrl u_write_ctrl (
    .wr_req_i (wr_req_i),
    .wdata_o  (wdata),
    .strobe_o (strobe)
  );

  csr_trap_regs u_trap_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .wdata_i        (wdata),
    .strobe_i       (strobe),
    .trap_i         (trap_i),
    .mstatus_o      (mstatus),
    .mie_o          (mie_o),
    .mtvec_o        (mtvec),
    .mscratch_o     (mscratch),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause),
    .m_irq_enable_o (m_irq_enable_o)
  );

  csr_counters u_counters (
    .clk             (clk),
    .rst_n           (rst_n),
    .wdata_i         (wdata),
    .strobe_i        (strobe),
    .retire_i        (retire_i),
    .mcycle_o        (mcycle),
    .minstret_o      (minstret),
    .mcountinhibit_o (mcountinhibit)
  );

  csr_read_mux u_read_mux (
    .rd_req_i           (rd_req_i),
    .mstatus_i          (mstatus),
    .mie_i              (mie_o),
    .mtvec_i            (mtvec),
    .mscratch_i         (mscratch),
    .mepc_i             (mepc_o),
    .mcause_i           (mcause),
    .mcycle_i           (mcycle),
    .minstret_i         (minstret),
    .mcountinhibit_i    (mcountinhibit),
    .hart_id_i          (hart_id_i),
    .mip_i              (mip_i),
    .csr_rdata_o        (csr_rdata_o),
    .csr_illegal_o      (csr_illegal_o),
    .csr_counter_read_o (csr_counter_read_o)
  );

  assign mtvec_base_o = mtvec.base;  // To the fetch stage for trap redirect
  assign mtvec_mode_o = mtvec.mode;

endmodule

//--- verilog/csr_trap_regs.sv
// Machine trap registers: mstatus, mie, mtvec, mscratch, mepc, mcause
// Software writes arrive as strobes, trap entry and MRET from the controller
// A trap update overrides a software write in the same cycle

`timescale 1ns/1ns

module csr_trap_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [csr_arch_pkg::XLEN-1:0] wdata_i,
  input  csr_port_pkg::csr_wr_strobe_t  strobe_i,
  input  csr_port_pkg::trap_ctrl_t      trap_i,
  output csr_arch_pkg::mstatus_t        mstatus_o,
  output logic [csr_arch_pkg::XLEN-1:0] mie_o,
  output csr_arch_pkg::mtvec_t          mtvec_o,
  output logic [csr_arch_pkg::XLEN-1:0] mscratch_o,
  output logic [csr_arch_pkg::XLEN-1:0] mepc_o,
  output csr_arch_pkg::mcause_t         mcause_o,
  output logic                          m_irq_enable_o
);

  import csr_arch_pkg::*;

  mstatus_t          mstatus_q, mstatus_d;
  logic [XLEN-1:0]   mie_q, mie_d;
  mtvec_t            mtvec_q, mtvec_d;
  logic [XLEN-1:0]   mscratch_q;
  logic [XLEN-1:0]   mepc_q, mepc_d;
  mcause_t           mcause_q, mcause_d;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d = mstatus_q;
    mie_d     = mie_q;
    mtvec_d   = mtvec_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    // Software writes, masked to the implemented fields
    if (strobe_i.mstatus)
      mstatus_d = '{mpp: PRIV_M, mpie: wdata_i[7], mie: wdata_i[3], default: '0};
    if (strobe_i.mie)    mie_d   = wdata_i & IRQ_MASK;
    if (strobe_i.mtvec)  mtvec_d = '{base: wdata_i[31:8], mode: {1'b0, wdata_i[0]}, default: '0};
    if (strobe_i.mepc)   mepc_d  = {wdata_i[XLEN-1:1], 1'b0};  // Halfword aligned
    if (strobe_i.mcause)
      mcause_d = '{interrupt: wdata_i[31], exception_code: wdata_i[7:0], default: '0};

    // Controller updates come last so they win
    if (trap_i.save_cause) begin
      mstatus_d = '{mpp: PRIV_M, mpie: mstatus_q.mie, mie: 1'b0, default: '0};
      mepc_d    = {trap_i.epc[XLEN-1:1], 1'b0};
      mcause_d  = '{interrupt:      trap_i.cause.interrupt,
                    exception_code: trap_i.cause.exception_code,
                    default:        '0};
    end else if (trap_i.restore_mret) begin
      // Back to the enable saved at trap entry
      mstatus_d = '{mpp: PRIV_M, mpie: 1'b1, mie: mstatus_q.mpie, default: '0};
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= MSTATUS_RESET_VAL;
      mie_q     <= '0;               // All interrupts masked
      mtvec_q   <= MTVEC_RESET_VAL;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mie_q     <= mie_d;
      mtvec_q   <= mtvec_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  // Scratch is plain software storage
  always_ff @(posedge clk) begin
    if (strobe_i.mscratch) mscratch_q <= wdata_i;
  end

  assign mstatus_o      = mstatus_q;
  assign mie_o          = mie_q;
  assign mtvec_o        = mtvec_q;
  assign mscratch_o     = mscratch_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign m_irq_enable_o = mstatus_q.mie;  // Global machine interrupt enable

endmodule

//--- verilog/csr_write_ctrl.sv
// Writeback side of the CSR file
// Turns a write request into the new register value and one write strobe

`timescale 1ns/1ns

module csr_write_ctrl (
  input  csr_port_pkg::csr_wr_req_t     wr_req_i,
  output logic [csr_arch_pkg::XLEN-1:0] wdata_o,   // Value after the operation
  output csr_port_pkg::csr_wr_strobe_t  strobe_o
);

  import csr_arch_pkg::*;
  import csr_port_pkg::*;

  logic wr_en;  // Valid and not a plain read

  // Read-modify-write against the value sampled in execute
  always_comb begin
    wr_en = wr_req_i.valid;
    case (wr_req_i.op)
      CSR_OP_WRITE: wdata_o = wr_req_i.wdata;
      CSR_OP_SET:   wdata_o = wr_req_i.wdata | wr_req_i.rdata_old;
      CSR_OP_CLEAR: wdata_o = ~wr_req_i.wdata & wr_req_i.rdata_old;
      default: begin
        wdata_o = wr_req_i.wdata;  // Don't care, no strobe follows
        wr_en   = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  // Read-only and read-zero addresses get no strobe, the write just drops
  always_comb begin
    strobe_o = '0;
    if (wr_en) begin
      case (wr_req_i.addr)
        CSR_MSTATUS:       strobe_o.mstatus       = 1'b1;
        CSR_MIE:           strobe_o.mie           = 1'b1;
        CSR_MTVEC:         strobe_o.mtvec         = 1'b1;
        CSR_MSCRATCH:      strobe_o.mscratch      = 1'b1;
        CSR_MEPC:          strobe_o.mepc          = 1'b1;
        CSR_MCAUSE:        strobe_o.mcause        = 1'b1;
        CSR_MCYCLE:        strobe_o.mcycle_lo     = 1'b1;
        CSR_MCYCLEH:       strobe_o.mcycle_hi     = 1'b1;
        CSR_MINSTRET:      strobe_o.minstret_lo   = 1'b1;
        CSR_MINSTRETH:     strobe_o.minstret_hi   = 1'b1;
        CSR_MCOUNTINHIBIT: strobe_o.mcountinhibit = 1'b1;
        default: ;
      endcase
    end
  end

endmodule
